//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int INSTR_W  = 32;
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int REG_W    = 5;
    localparam int SHAMT_W  = 5;
    localparam int IMM_W    = 16;

    typedef logic [REG_W-1:0] reg_idx_t;

    // primary opcode in bits 31:26, only the supported ones are listed
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'h00, // R-type, the real work is in funct
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL words, bits 5:0
    typedef enum logic [FUNCT_W-1:0] {
        FUNCT_SLL     = 6'h00,
        FUNCT_SRL     = 6'h02,
        FUNCT_SYSCALL = 6'h0c,
        FUNCT_MFHI    = 6'h10,
        FUNCT_MTHI    = 6'h11,
        FUNCT_MFLO    = 6'h12,
        FUNCT_MTLO    = 6'h13,
        FUNCT_MULTU   = 6'h19,
        FUNCT_ADDU    = 6'h21,
        FUNCT_SUBU    = 6'h23,
        FUNCT_AND     = 6'h24,
        FUNCT_OR      = 6'h25,
        FUNCT_SLT     = 6'h2a
    } funct_e;

endpackage

`default_nettype wire

//--- rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SHIFT_LEFT,
        ALU_SHIFT_RIGHT_LOGIC,
        ALU_LUI // imm shifted into the upper half
    } alu_op_e;

    typedef enum logic {ALU_B_RT, ALU_B_IMM} alu_b_src_e;

    typedef enum logic {IMM_EXT_SIGN, IMM_EXT_ZERO} imm_ext_e;

    typedef enum logic [1:0] {DEST_REG_NONE, DEST_REG_RD, DEST_REG_RT, DEST_REG_R31} dest_reg_e;

    // write-back data source, PC8 is the link address of JAL
    typedef enum logic [2:0] {
        REG_SRC_ALU,
        REG_SRC_MEM,
        REG_SRC_HI,
        REG_SRC_LO,
        REG_SRC_PC8
    } reg_src_e;

    typedef enum logic {HILO_SRC_RS, HILO_SRC_MULDIV} hilo_src_e;

    typedef enum logic [1:0] {MULDIV_NONE, MULDIV_MULTU} muldiv_funct_e;

    typedef enum logic [1:0] {PC_SRC_SEQ, PC_SRC_BRANCH, PC_SRC_JUMP, PC_SRC_EXCEPTION} pc_src_e;

    typedef enum logic [1:0] {EXC_CHK_NONE, EXC_CHK_SYSCALL, EXC_CHK_RESERVED} exc_chk_e;

    // one decoded instruction worth of control, 24 bits
    typedef struct packed {
        alu_op_e       alu_op;
        alu_b_src_e    alu_b_src;
        imm_ext_e      imm_ext;
        logic          shamt_use;    // shift amount comes from the shamt field
        dest_reg_e     dest_reg;
        logic          reg_write;
        reg_src_e      reg_src;
        hilo_src_e     hilo_src;
        logic          write_hi;
        logic          write_lo;
        muldiv_funct_e muldiv_funct;
        pc_src_e       pc_src;
        exc_chk_e      exc_chk;
        logic          mem_read;
        logic          mem_write;
    } control_t;

    // a harmless control word, nothing is written and the pc just moves on
    function automatic control_t clear_control();
        control_t c;
        c.alu_op       = ALU_ADD;
        c.alu_b_src    = ALU_B_RT;
        c.imm_ext      = IMM_EXT_SIGN;
        c.shamt_use    = 1'b0;
        c.dest_reg     = DEST_REG_NONE;
        c.reg_write    = 1'b0;
        c.reg_src      = REG_SRC_ALU;
        c.hilo_src     = HILO_SRC_RS;
        c.write_hi     = 1'b0;
        c.write_lo     = 1'b0;
        c.muldiv_funct = MULDIV_NONE;
        c.pc_src       = PC_SRC_SEQ;
        c.exc_chk      = EXC_CHK_NONE;
        c.mem_read     = 1'b0;
        c.mem_write    = 1'b0;
        return c;
    endfunction

endpackage

`default_nettype wire

//--- rtl/decode_if.sv
`timescale 1ns/1ns
`default_nettype none

// one decoded instruction with its valid/ready handshake
interface decode_if;
    import ctrl_pkg::*;
    import isa_pkg::*;

    logic               valid;
    logic               ready;
    control_t           ctl;
    reg_idx_t           rs;
    reg_idx_t           rt;
    reg_idx_t           rd;
    logic [IMM_W-1:0]   imm;   // raw, extension is left to the execute stage
    logic [SHAMT_W-1:0] shamt;

    modport producer (
        output valid, ctl, rs, rt, rd, imm, shamt,
        input  ready
    );

    modport consumer (
        input  valid, ctl, rs, rt, rd, imm, shamt,
        output ready
    );

endinterface

`default_nettype wire

//--- rtl/rtype_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module rtype_decoder (
    input  isa_pkg::funct_e   funct,
    output ctrl_pkg::control_t ctl
);
    import ctrl_pkg::*;
    import isa_pkg::*;

    // R-type words read rs as operand A and rt as operand B, the result goes to rd

    always_comb begin
        ctl = clear_control();

        case (funct)
            FUNCT_SLL, FUNCT_SRL: begin
                ctl.alu_op    = (funct == FUNCT_SLL) ? ALU_SHIFT_LEFT : ALU_SHIFT_RIGHT_LOGIC;
                ctl.shamt_use = 1'b1; // shift amount is the shamt field, not rs
                ctl.alu_b_src = ALU_B_RT;
                ctl.dest_reg  = DEST_REG_RD;
                ctl.reg_write = 1'b1;
                ctl.reg_src   = REG_SRC_ALU;
            end

            FUNCT_ADDU, FUNCT_SUBU, FUNCT_AND, FUNCT_OR, FUNCT_SLT: begin
                case (funct)
                    FUNCT_SUBU: ctl.alu_op = ALU_SUB;
                    FUNCT_AND:  ctl.alu_op = ALU_AND;
                    FUNCT_OR:   ctl.alu_op = ALU_OR;
                    FUNCT_SLT:  ctl.alu_op = ALU_SLT;
                    default:    ctl.alu_op = ALU_ADD;
                endcase
                ctl.alu_b_src = ALU_B_RT;
                ctl.dest_reg  = DEST_REG_RD;
                ctl.reg_write = 1'b1;
                ctl.reg_src   = REG_SRC_ALU;
            end

            FUNCT_MFHI, FUNCT_MFLO: begin
                ctl.dest_reg  = DEST_REG_RD;
                ctl.reg_write = 1'b1;
                ctl.reg_src   = (funct == FUNCT_MFHI) ? REG_SRC_HI : REG_SRC_LO;
            end

            FUNCT_MTHI: begin
                ctl.hilo_src = HILO_SRC_RS;
                ctl.write_hi = 1'b1;
            end

            FUNCT_MTLO: begin
                ctl.hilo_src = HILO_SRC_RS;
                ctl.write_lo = 1'b1;
            end

            FUNCT_MULTU: begin
                // the 64-bit product lands in hi and lo together
                ctl.hilo_src     = HILO_SRC_MULDIV;
                ctl.muldiv_funct = MULDIV_MULTU;
                ctl.write_hi     = 1'b1;
                ctl.write_lo     = 1'b1;
            end

            FUNCT_SYSCALL: begin
                ctl.pc_src  = PC_SRC_EXCEPTION;
                ctl.exc_chk = EXC_CHK_SYSCALL;
            end

            default: begin
                ctl.pc_src  = PC_SRC_EXCEPTION;
                ctl.exc_chk = EXC_CHK_RESERVED;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/main_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module main_decoder (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          instr_valid,
    output logic                         instr_ready,
    input  wire [isa_pkg::INSTR_W-1:0]   instr,
    decode_if.producer                   dec
);
    import ctrl_pkg::*;
    import isa_pkg::*;

    opcode_e  opcode;
    funct_e   funct;
    control_t rtype_ctl;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);

    // the handshake passes straight through, the queue decides when to accept
    assign dec.valid   = instr_valid;
    assign instr_ready = dec.ready;

    assign dec.rs    = instr[25:21];
    assign dec.rt    = instr[20:16];
    assign dec.rd    = instr[15:11];
    assign dec.shamt = instr[10:6];
    assign dec.imm   = instr[15:0];

    rtype_decoder rtype_decoder_i (
        .funct (funct),
        .ctl   (rtype_ctl)
    );

    always_comb begin
        dec.ctl = clear_control();

        case (opcode)
            OP_SPECIAL: dec.ctl = rtype_ctl;

            OP_ADDIU, OP_ORI, OP_LUI, OP_LW, OP_SW: begin
                dec.ctl.alu_b_src = ALU_B_IMM;
                dec.ctl.alu_op    = ALU_ADD; // address add for the loads and stores
                dec.ctl.imm_ext   = IMM_EXT_SIGN;
                dec.ctl.dest_reg  = DEST_REG_RT;
                dec.ctl.reg_write = 1'b1;
                if (opcode == OP_ORI) begin
                    dec.ctl.alu_op  = ALU_OR;
                    dec.ctl.imm_ext = IMM_EXT_ZERO;
                end
                if (opcode == OP_LUI) begin
                    dec.ctl.alu_op  = ALU_LUI;
                    dec.ctl.imm_ext = IMM_EXT_ZERO;
                end
                if (opcode == OP_LW) begin
                    dec.ctl.reg_src  = REG_SRC_MEM;
                    dec.ctl.mem_read = 1'b1;
                end
                if (opcode == OP_SW) begin
                    dec.ctl.dest_reg  = DEST_REG_NONE;
                    dec.ctl.reg_write = 1'b0;
                    dec.ctl.mem_write = 1'b1;
                end
            end

            OP_BEQ: begin
                // the compare is a subtract of rs and rt
                dec.ctl.alu_op    = ALU_SUB;
                dec.ctl.alu_b_src = ALU_B_RT;
                dec.ctl.pc_src    = PC_SRC_BRANCH;
            end

            OP_J: dec.ctl.pc_src = PC_SRC_JUMP;

            OP_JAL: begin
                dec.ctl.pc_src    = PC_SRC_JUMP;
                dec.ctl.dest_reg  = DEST_REG_R31;
                dec.ctl.reg_write = 1'b1;
                dec.ctl.reg_src   = REG_SRC_PC8; // link address is pc + 8
            end

            default: begin
                dec.ctl.pc_src  = PC_SRC_EXCEPTION;
                dec.ctl.exc_chk = EXC_CHK_RESERVED;
            end
        endcase
    end

    // the fetch side must not change a word that is still waiting to be taken
    a_instr_stable: assert property (@(posedge clk) disable iff (reset)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr))
        else $error("main_decoder: instr changed while stalled");

endmodule

`default_nettype wire

//--- rtl/decode_queue.sv
`timescale 1ns/1ns
`default_nettype none

module decode_queue #(
    parameter int QUEUE_DEPTH = 2
) (
    input  wire                              clk,
    input  wire                              reset,
    decode_if.consumer                       dec,
    output logic                             out_valid,
    input  wire                              out_ready,
    output ctrl_pkg::control_t               out_ctl,
    output isa_pkg::reg_idx_t                out_rs,
    output isa_pkg::reg_idx_t                out_rt,
    output isa_pkg::reg_idx_t                out_rd,
    output logic [isa_pkg::IMM_W-1:0]        out_imm,
    output logic [isa_pkg::SHAMT_W-1:0]      out_shamt
);
    import ctrl_pkg::*;
    import isa_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef struct packed {
        control_t           ctl;
        reg_idx_t           rs;
        reg_idx_t           rt;
        reg_idx_t           rd;
        logic [IMM_W-1:0]   imm;
        logic [SHAMT_W-1:0] shamt;
    } entry_t;

    entry_t             mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    assign dec.ready = (count != CNT_W'(QUEUE_DEPTH)); // accept only with a free slot
    assign out_valid = (count != '0);
    assign push      = dec.valid && dec.ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= '{ctl: dec.ctl, rs: dec.rs, rt: dec.rt, rd: dec.rd,
                             imm: dec.imm, shamt: dec.shamt};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // a push and a pop in the same cycle leave the count alone
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    assign out_ctl   = mem[rd_ptr].ctl;
    assign out_rs    = mem[rd_ptr].rs;
    assign out_rt    = mem[rd_ptr].rt;
    assign out_rd    = mem[rd_ptr].rd;
    assign out_imm   = mem[rd_ptr].imm;
    assign out_shamt = mem[rd_ptr].shamt;

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(QUEUE_DEPTH))
        else $error("decode_queue: count %0d above depth", count);

    // the head entry stays put until the next stage takes it
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(mem[rd_ptr]))
        else $error("decode_queue: output changed under back-pressure");

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage #(
    parameter int QUEUE_DEPTH = 2
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              instr_valid,
    output logic                             instr_ready,
    input  wire [isa_pkg::INSTR_W-1:0]       instr,
    output logic                             out_valid,
    input  wire                              out_ready,
    output ctrl_pkg::control_t               out_ctl,
    output isa_pkg::reg_idx_t                out_rs,
    output isa_pkg::reg_idx_t                out_rt,
    output isa_pkg::reg_idx_t                out_rd,
    output logic [isa_pkg::IMM_W-1:0]        out_imm,
    output logic [isa_pkg::SHAMT_W-1:0]      out_shamt
);

    decode_if dec_if ();

    // combinational decode in front of the queue, so one cycle from accept to output
    main_decoder main_decoder_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .dec         (dec_if.producer)
    );

    decode_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) decode_queue_i (
        .clk       (clk),
        .reset     (reset),
        .dec       (dec_if.consumer),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_ctl   (out_ctl),
        .out_rs    (out_rs),
        .out_rt    (out_rt),
        .out_rd    (out_rd),
        .out_imm   (out_imm),
        .out_shamt (out_shamt)
    );

endmodule

`default_nettype wire

//--- tb/decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH
`default_nettype none

// expected control word for one instruction, built from the MIPS32 encodings
function automatic ctrl_pkg::control_t expected_control(input logic [31:0] w);
    ctrl_pkg::control_t c;
    logic [5:0] op;
    logic [5:0] fn;
    logic       reserved;
    op       = w[31:26];
    fn       = w[5:0];
    reserved = 1'b0;
    c        = '0; // the first value of every selector is the idle one
    case (op)
        6'h00: begin
            case (fn)
                6'h00, 6'h02, 6'h21, 6'h23, 6'h24, 6'h25, 6'h2a: begin
                    c.shamt_use = (fn == 6'h00) || (fn == 6'h02);
                    c.dest_reg  = ctrl_pkg::DEST_REG_RD;
                    c.reg_write = 1'b1;
                    case (fn)
                        6'h00:   c.alu_op = ctrl_pkg::ALU_SHIFT_LEFT;
                        6'h02:   c.alu_op = ctrl_pkg::ALU_SHIFT_RIGHT_LOGIC;
                        6'h23:   c.alu_op = ctrl_pkg::ALU_SUB;
                        6'h24:   c.alu_op = ctrl_pkg::ALU_AND;
                        6'h25:   c.alu_op = ctrl_pkg::ALU_OR;
                        6'h2a:   c.alu_op = ctrl_pkg::ALU_SLT;
                        default: c.alu_op = ctrl_pkg::ALU_ADD; // addu
                    endcase
                end
                6'h10, 6'h12: begin // mfhi and mflo
                    c.dest_reg  = ctrl_pkg::DEST_REG_RD;
                    c.reg_write = 1'b1;
                    c.reg_src   = (fn == 6'h10) ? ctrl_pkg::REG_SRC_HI : ctrl_pkg::REG_SRC_LO;
                end
                6'h11:   c.write_hi = 1'b1; // mthi takes rs
                6'h13:   c.write_lo = 1'b1;
                6'h19: begin
                    c.hilo_src     = ctrl_pkg::HILO_SRC_MULDIV;
                    c.muldiv_funct = ctrl_pkg::MULDIV_MULTU;
                    c.write_hi     = 1'b1;
                    c.write_lo     = 1'b1;
                end
                6'h0c: begin
                    c.pc_src  = ctrl_pkg::PC_SRC_EXCEPTION;
                    c.exc_chk = ctrl_pkg::EXC_CHK_SYSCALL;
                end
                default: reserved = 1'b1;
            endcase
        end
        6'h09, 6'h0d, 6'h0f, 6'h23, 6'h2b: begin
            c.alu_b_src = ctrl_pkg::ALU_B_IMM;
            c.dest_reg  = ctrl_pkg::DEST_REG_RT;
            c.reg_write = 1'b1;
            if (op == 6'h0d) begin
                c.alu_op  = ctrl_pkg::ALU_OR;
                c.imm_ext = ctrl_pkg::IMM_EXT_ZERO;
            end
            if (op == 6'h0f) begin
                c.alu_op  = ctrl_pkg::ALU_LUI;
                c.imm_ext = ctrl_pkg::IMM_EXT_ZERO;
            end
            if (op == 6'h23) begin
                c.reg_src  = ctrl_pkg::REG_SRC_MEM;
                c.mem_read = 1'b1;
            end
            if (op == 6'h2b) begin // a store writes memory only
                c.dest_reg  = ctrl_pkg::DEST_REG_NONE;
                c.reg_write = 1'b0;
                c.mem_write = 1'b1;
            end
        end
        6'h04: begin
            c.alu_op = ctrl_pkg::ALU_SUB;
            c.pc_src = ctrl_pkg::PC_SRC_BRANCH;
        end
        6'h02:   c.pc_src = ctrl_pkg::PC_SRC_JUMP;
        6'h03: begin
            c.pc_src    = ctrl_pkg::PC_SRC_JUMP;
            c.dest_reg  = ctrl_pkg::DEST_REG_R31;
            c.reg_write = 1'b1;
            c.reg_src   = ctrl_pkg::REG_SRC_PC8;
        end
        default: reserved = 1'b1;
    endcase
    if (reserved) begin
        c.pc_src  = ctrl_pkg::PC_SRC_EXCEPTION;
        c.exc_chk = ctrl_pkg::EXC_CHK_RESERVED;
    end
    return c;
endfunction

`default_nettype wire
`endif

//--- tb/tb_decode_stage.sv
`timescale 1ns/1ns
`include "decode_ref_model.svh"
`default_nettype none

module tb_decode_stage;
    import ctrl_pkg::*;
    import isa_pkg::*;

    localparam int MAX_WAIT = 100;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr;
    logic        out_valid;
    logic        out_ready;
    control_t    out_ctl;
    reg_idx_t    out_rs;
    reg_idx_t    out_rt;
    reg_idx_t    out_rd;
    logic [15:0] out_imm;
    logic [4:0]  out_shamt;

    logic [31:0] sent_q [$];              // accepted words still owed by the output side
    logic [31:0] rng_state    = 32'd59889;
    logic        random_ready = 1'b0;     // out_ready toggles randomly each cycle when set
    logic [5:0]  supported_ops [9]     = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h09,
                                           6'h0d, 6'h0f, 6'h23, 6'h2b};
    logic [5:0]  supported_functs [13] = '{6'h00, 6'h02, 6'h21, 6'h23, 6'h24, 6'h25,
                                           6'h2a, 6'h10, 6'h11, 6'h12, 6'h13, 6'h19, 6'h0c};
    logic [5:0]  bad_codes [4]         = '{6'h01, 6'h08, 6'h1c, 6'h3f};

    always #20 clk = ~clk;

    decode_stage #(.QUEUE_DEPTH(2)) decode_stage_i (.*);

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // the head entry is checked against the oldest word still owed
    task automatic compare_head();
        logic [31:0] w;
        control_t    exp;
        assert (sent_q.size() > 0) else begin
            $display("the DUT delivered an entry that was never sent, at %0t", $time);
            abort_run();
        end
        w   = sent_q.pop_front();
        exp = expected_control(w);
        compare_value("out_ctl", 32'(out_ctl), 32'(exp));
        compare_value("out_rs", 32'(out_rs), 32'(w[25:21]));
        compare_value("out_rt", 32'(out_rt), 32'(w[20:16]));
        compare_value("out_rd", 32'(out_rd), 32'(w[15:11]));
        compare_value("out_imm", 32'(out_imm), 32'(w[15:0]));
        compare_value("out_shamt", 32'(out_shamt), 32'(w[10:6]));
    endtask

    // called at a falling edge with the inputs already driven
    task automatic step_cycle(output logic taken);
        logic        popped;
        logic [31:0] r;
        popped = out_valid && out_ready;
        taken  = instr_valid && instr_ready;
        if (popped)
            compare_head();
        if (taken)
            sent_q.push_back(instr);
        @(negedge clk);
        if (random_ready) begin
            r         = xorshift32();
            out_ready = (r[1:0] != 2'b00);
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        logic taken;
        int   waited;
        taken       = 1'b0;
        waited      = 0;
        instr_valid = 1'b1;
        instr       = w;
        while (!taken && waited < MAX_WAIT) begin
            step_cycle(taken);
            waited++;
        end
        if (!taken) begin
            $display("timeout: the DUT never accepted instruction %h", w);
            abort_run();
        end
        instr_valid = 1'b0;
    endtask

    task automatic drain_queue();
        logic taken;
        int   waited;
        waited       = 0;
        random_ready = 1'b0;
        out_ready    = 1'b1;
        while (sent_q.size() > 0 && waited < MAX_WAIT) begin
            step_cycle(taken);
            waited++;
        end
        if (sent_q.size() > 0) begin
            $display("timeout: %0d entries never came out of the DUT", sent_q.size());
            abort_run();
        end
        compare_value("out_valid after drain", 32'(out_valid), 32'd0);
    endtask

    task automatic reset_state_test();
        compare_value("out_valid after reset", 32'(out_valid), 32'd0);
        compare_value("instr_ready after reset", 32'(instr_ready), 32'd1);
    endtask

    task automatic rtype_funct_test();
        logic [31:0] r;
        out_ready = 1'b1;
        for (int i = 0; i < 13; i++) begin
            r = xorshift32();
            send_word({6'h00, r[25:6], supported_functs[i]});
        end
        drain_queue();
    endtask

    task automatic opcode_test();
        logic [31:0] r;
        out_ready = 1'b1;
        for (int i = 0; i < 9; i++) begin
            r = xorshift32();
            send_word({supported_ops[i], r[25:0]});
        end
        drain_queue();
    endtask

    task automatic exception_test();
        logic [31:0] r;
        out_ready = 1'b1;
        for (int i = 0; i < 4; i++) begin
            r = xorshift32();
            send_word({bad_codes[i], r[25:0]});            // reserved opcode
            send_word({6'h00, r[25:6], bad_codes[i]});     // reserved funct
        end
        r = xorshift32();
        send_word({6'h00, r[25:6], 6'h0c});
        drain_queue();
    endtask

    // two entries fill the queue, a third word has to wait at the input
    task automatic back_pressure_test();
        logic [31:0] r;
        logic        taken;
        out_ready = 1'b0;
        r = xorshift32();
        send_word({6'h09, r[25:0]});
        compare_value("instr_ready after one accept", 32'(instr_ready), 32'd1);
        r = xorshift32();
        send_word({6'h0d, r[25:0]});
        compare_value("instr_ready after two accepts", 32'(instr_ready), 32'd0);
        r           = xorshift32();
        instr_valid = 1'b1;
        instr       = {6'h23, r[25:0]};
        repeat (3) begin
            step_cycle(taken);
            compare_value("accept while full", 32'(taken), 32'd0);
        end
        out_ready = 1'b1;
        send_word({6'h23, r[25:0]});
        drain_queue();
    endtask

    task automatic random_stream_test();
        logic [31:0] w;
        logic [31:0] sel;
        logic        taken;
        random_ready = 1'b1;
        for (int n = 0; n < 200; n++) begin
            w   = xorshift32();
            sel = xorshift32();
            // bias toward supported encodings so the decoders see real work
            if (sel[0])
                w[31:26] = supported_ops[int'(sel % 32'd9)];
            if (w[31:26] == 6'h00 && sel[5])
                w[5:0] = supported_functs[int'((sel >> 8) % 32'd13)];
            repeat (int'(sel[7:6]))
                step_cycle(taken);
            send_word(w);
        end
        drain_queue();
    endtask

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        out_ready   = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_state_test();
        rtype_funct_test();
        opcode_test();
        exception_test();
        back_pressure_test();
        random_stream_test();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+tb
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/decode_if.sv
rtl/rtype_decoder.sv
rtl/main_decoder.sv
rtl/decode_queue.sv
rtl/decode_stage.sv
tb/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_decode_stage \
    -Mdir obj_dir -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_decode_stage
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
echo "simulation finished"
exit 0
